// ==== verilog/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

   // --------------------------------------------------
   // widths and fixed values
   // --------------------------------------------------
   localparam int xlen       = 32;
   localparam int reg_addr_w = 5;

   typedef logic [xlen-1:0]       word_t;
   typedef logic [reg_addr_w-1:0] reg_addr_t;

   localparam word_t pc_step  = 32'd4;
   localparam word_t reset_pc = 32'h0000_0000;
   localparam word_t nop_inst = 32'h0000_0013;     // addi x0,x0,0

   // --------------------------------------------------
   // encodings
   // --------------------------------------------------
   typedef enum logic [6:0] {
      op_r      = 7'b0110011,
      op_imm    = 7'b0010011,
      op_load   = 7'b0000011,
      op_store  = 7'b0100011,
      op_branch = 7'b1100011,
      op_lui    = 7'b0110111,
      op_jal    = 7'b1101111
   } opcode_t;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_sll
   } alu_op_t;

   typedef enum logic [1:0] {
      fwd_none,                                    // register file value
      fwd_mem,                                     // from EX/MEM
      fwd_wb                                       // from MEM/WB
   } fwd_sel_t;

   // values are the branch funct3 field
   typedef enum logic [2:0] {
      br_eq  = 3'b000,
      br_ne  = 3'b001,
      br_lt  = 3'b100,
      br_ge  = 3'b101,
      br_ltu = 3'b110,
      br_geu = 3'b111
   } branch_cond_t;

endpackage

`default_nettype wire

// ==== verilog/rv_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_decoder (
   input  rv_pkg::word_t   inst,
   output logic            reg_write,
   output logic            mem_to_reg,
   output logic            mem_write,
   output logic            alu_src_imm,
   output logic            branch,
   output logic            jal,
   output logic            lui,
   output logic            uses_rs2,
   output rv_pkg::alu_op_t alu_op,
   output rv_pkg::word_t   imm
);
   import rv_pkg::*;

   opcode_t    opcode;
   logic [2:0] funct3;
   logic       funct7_5;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm_j;
   word_t      imm_u;

   // shared by R-type and immediate arithmetic
   function automatic alu_op_t arith_op(input logic [2:0] f3, input logic sub);
      case (f3)
         3'b000:  return sub ? alu_sub : alu_add;
         3'b111:  return alu_and;
         3'b110:  return alu_or;
         3'b100:  return alu_xor;
         3'b001:  return alu_sll;
         default: return alu_add;
      endcase
   endfunction

   assign opcode   = opcode_t'(inst[6:0]);
   assign funct3   = inst[14:12];
   assign funct7_5 = inst[30];                     // sub vs add

   assign imm_i = {{20{inst[31]}}, inst[31:20]};
   assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
   assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
   assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
   assign imm_u = {inst[31:12], 12'b0};

   always_comb
   begin
      reg_write   = 1'b0;
      mem_to_reg  = 1'b0;
      mem_write   = 1'b0;
      alu_src_imm = 1'b0;
      branch      = 1'b0;
      jal         = 1'b0;
      lui         = 1'b0;
      uses_rs2    = 1'b0;
      alu_op      = alu_add;
      imm         = imm_i;
      case (opcode)
         op_r:
         begin
            reg_write = 1'b1;
            uses_rs2  = 1'b1;
            alu_op    = arith_op(funct3, funct7_5);
         end
         op_imm:
         begin
            reg_write   = 1'b1;
            alu_src_imm = 1'b1;
            alu_op      = arith_op(funct3, 1'b0);
         end
         op_load:
         begin
            reg_write   = 1'b1;
            mem_to_reg  = 1'b1;
            alu_src_imm = 1'b1;                    // address is rs1 + imm
         end
         op_store:
         begin
            mem_write   = 1'b1;
            alu_src_imm = 1'b1;
            uses_rs2    = 1'b1;
            imm         = imm_s;
         end
         op_branch:
         begin
            branch   = 1'b1;
            uses_rs2 = 1'b1;
            alu_op   = alu_sub;                    // flags only
            imm      = imm_b;
         end
         op_lui:
         begin
            reg_write   = 1'b1;
            lui         = 1'b1;
            alu_src_imm = 1'b1;
            imm         = imm_u;
         end
         op_jal:
         begin
            reg_write = 1'b1;                      // link written later
            jal       = 1'b1;
            imm       = imm_j;
         end
         default:
         begin
            imm = imm_i;                           // unknown, nothing written
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
   input  logic              clk,
   input  logic              we,
   input  rv_pkg::reg_addr_t rs1,
   input  rv_pkg::reg_addr_t rs2,
   input  rv_pkg::reg_addr_t rd,
   input  rv_pkg::word_t     rd_data,
   output rv_pkg::word_t     rs1_data,
   output rv_pkg::word_t     rs2_data
);
   import rv_pkg::*;

   word_t regs [1:31];                             // x0 has no storage

   function automatic word_t read_port(input reg_addr_t addr);
      if (addr == '0)
         return '0;
      else if (we && addr == rd)
         return rd_data;                           // write-through
      else
         return regs[addr];
   endfunction

   always_ff @(posedge clk)
   begin
      if (we && rd != '0)
         regs[rd] <= rd_data;
   end

   always_comb
   begin
      rs1_data = read_port(rs1);
      rs2_data = read_port(rs2);
   end

endmodule

`default_nettype wire

// ==== verilog/rv_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
   input  rv_pkg::word_t   a,
   input  rv_pkg::word_t   b,
   input  rv_pkg::alu_op_t alu_op,
   output rv_pkg::word_t   result,
   output logic            n,
   output logic            z,
   output logic            c,
   output logic            v
);
   import rv_pkg::*;

   word_t diff;

   // flags always come from a - b, whatever the operation
   assign {c, diff} = {1'b0, a} + {1'b0, ~b} + 33'd1;   // c set when a >= b unsigned

   assign n = diff[xlen-1];
   assign z = (diff == '0);
   assign v = (a[xlen-1] != b[xlen-1]) && (diff[xlen-1] != a[xlen-1]);

   always_comb
   begin
      case (alu_op)
         alu_add: result = a + b;
         alu_sub: result = diff;
         alu_and: result = a & b;
         alu_or:  result = a | b;
         alu_xor: result = a ^ b;
         alu_sll: result = a << b[4:0];            // shamt is low five bits
         default: result = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/rv_hazard_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_hazard_unit (
   input  rv_pkg::reg_addr_t rs1_id,
   input  rv_pkg::reg_addr_t rs2_id,
   input  rv_pkg::reg_addr_t rs1_ex,
   input  rv_pkg::reg_addr_t rs2_ex,
   input  rv_pkg::reg_addr_t rd_ex,
   input  rv_pkg::reg_addr_t rd_mem,
   input  rv_pkg::reg_addr_t rd_wb,
   input  logic              uses_rs2_id,
   input  logic              mem_to_reg_ex,
   input  logic              reg_write_mem,
   input  logic              reg_write_wb,
   output rv_pkg::fwd_sel_t  fwd_a,
   output rv_pkg::fwd_sel_t  fwd_b,
   output logic              stall
);
   import rv_pkg::*;

   // youngest producer wins, x0 is never forwarded
   function automatic fwd_sel_t pick(input reg_addr_t src);
      if (reg_write_mem && rd_mem != '0 && rd_mem == src)
         return fwd_mem;
      else if (reg_write_wb && rd_wb != '0 && rd_wb == src)
         return fwd_wb;
      else
         return fwd_none;
   endfunction

   always_comb
   begin
      fwd_a = pick(rs1_ex);
      fwd_b = pick(rs2_ex);
   end

   // --------------------------------------------------
   // load-use
   // --------------------------------------------------
   // lui and jal may stall needlessly on rs1, which costs a cycle only
   assign stall = mem_to_reg_ex && rd_ex != '0 &&
                  (rd_ex == rs1_id || (uses_rs2_id && rd_ex == rs2_id));

endmodule

`default_nettype wire

// ==== verilog/rv_execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_execute (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 stall,
   input  rv_pkg::word_t        pc_id,
   input  logic                 reg_write_id,
   input  logic                 mem_to_reg_id,
   input  logic                 mem_write_id,
   input  logic                 alu_src_imm_id,
   input  logic                 branch_id,
   input  logic                 jal_id,
   input  logic                 lui_id,
   input  rv_pkg::alu_op_t      alu_op_id,
   input  rv_pkg::word_t        imm_id,
   input  rv_pkg::reg_addr_t    rs1_id,
   input  rv_pkg::reg_addr_t    rs2_id,
   input  rv_pkg::reg_addr_t    rd_id,
   input  rv_pkg::word_t        rs1_data,
   input  rv_pkg::word_t        rs2_data,
   input  rv_pkg::branch_cond_t funct3_id,
   input  rv_pkg::fwd_sel_t     fwd_a,
   input  rv_pkg::fwd_sel_t     fwd_b,
   input  rv_pkg::word_t        result_mem,
   input  rv_pkg::word_t        rd_data_wb,
   output rv_pkg::reg_addr_t    rs1_ex,
   output rv_pkg::reg_addr_t    rs2_ex,
   output rv_pkg::reg_addr_t    rd_ex,
   output logic                 mem_to_reg_ex,
   output logic                 reg_write_ex,
   output logic                 mem_write_ex,
   output logic                 jal_ex,
   output rv_pkg::word_t        result_ex,
   output rv_pkg::word_t        store_data_ex,
   output rv_pkg::word_t        link_ex,
   output rv_pkg::word_t        target,
   output logic                 redirect
);
   import rv_pkg::*;

   logic         alu_src_imm_ex;
   logic         branch_ex;
   logic         lui_ex;
   alu_op_t      alu_op_ex;
   branch_cond_t funct3_ex;
   word_t        pc_ex;
   word_t        imm_ex;
   word_t        rs1_data_ex;
   word_t        rs2_data_ex;
   word_t        fwd_a_data;
   word_t        op_a;
   word_t        op_b;
   logic         n;
   logic         z;
   logic         c;
   logic         v;
   logic         taken;
   logic         bubble;

   function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t own);
      case (sel)
         fwd_mem: return result_mem;
         fwd_wb:  return rd_data_wb;
         default: return own;
      endcase
   endfunction

   assign bubble = stall || redirect;

   // --------------------------------------------------
   // ID/EX register
   // --------------------------------------------------
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         {reg_write_ex, mem_to_reg_ex, mem_write_ex, branch_ex, jal_ex} <= '0;
      else if (bubble)
         {reg_write_ex, mem_to_reg_ex, mem_write_ex, branch_ex, jal_ex} <= '0;
      else
         {reg_write_ex, mem_to_reg_ex, mem_write_ex, branch_ex, jal_ex} <=
            {reg_write_id, mem_to_reg_id, mem_write_id, branch_id, jal_id};
   end

   always_ff @(posedge clk)
   begin
      alu_src_imm_ex <= alu_src_imm_id;
      lui_ex         <= lui_id;
      alu_op_ex      <= alu_op_id;
      funct3_ex      <= funct3_id;
      pc_ex          <= pc_id;
      imm_ex         <= imm_id;
      rs1_ex         <= rs1_id;
      rs2_ex         <= rs2_id;
      rd_ex          <= rd_id;
      rs1_data_ex    <= rs1_data;
      rs2_data_ex    <= rs2_data;
   end

   // operands
   always_comb
   begin
      fwd_a_data    = fwd_mux(fwd_a, rs1_data_ex);
      store_data_ex = fwd_mux(fwd_b, rs2_data_ex);   // store data shares rs2 path
      op_a          = lui_ex ? '0 : fwd_a_data;
      op_b          = alu_src_imm_ex ? imm_ex : store_data_ex;
   end

   rv_alu alu0 (
      .a      (op_a),
      .b      (op_b),
      .alu_op (alu_op_ex),
      .result (result_ex),
      .n      (n),
      .z      (z),
      .c      (c),
      .v      (v)
   );

   always_comb
   begin
      case (funct3_ex)
         br_eq:   taken = z;
         br_ne:   taken = !z;
         br_lt:   taken = (n != v);
         br_ge:   taken = (n == v);
         br_ltu:  taken = !c;
         br_geu:  taken = c;
         default: taken = 1'b0;
      endcase
   end

   assign redirect = jal_ex || (branch_ex && taken);
   assign target   = pc_ex + imm_ex;               // branch and jal alike
   assign link_ex  = pc_ex + pc_step;

endmodule

`default_nettype wire

// ==== verilog/rv_mem_wb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_mem_wb (
   input  logic              clk,
   input  logic              reset,
   input  rv_pkg::reg_addr_t rd_ex,
   input  logic              reg_write_ex,
   input  logic              mem_to_reg_ex,
   input  logic              mem_write_ex,
   input  logic              jal_ex,
   input  rv_pkg::word_t     result_ex,
   input  rv_pkg::word_t     store_data_ex,
   input  rv_pkg::word_t     link_ex,
   input  rv_pkg::word_t     mem_rdata,
   output logic              mem_write,
   output logic              reg_write_mem,
   output logic              reg_write_wb,
   output rv_pkg::word_t     result_mem,
   output rv_pkg::word_t     store_data,
   output rv_pkg::word_t     rd_data_wb,
   output rv_pkg::reg_addr_t rd_mem,
   output rv_pkg::reg_addr_t rd_wb
);
   import rv_pkg::*;

   logic  mem_to_reg_mem;
   logic  jal_mem;
   logic  mem_to_reg_wb;
   word_t alu_mem;
   word_t link_mem;
   word_t result_wb;
   word_t load_wb;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         {reg_write_mem, mem_to_reg_mem, mem_write, jal_mem} <= '0;
         {reg_write_wb, mem_to_reg_wb} <= '0;
      end
      else
      begin
         {reg_write_mem, mem_to_reg_mem, mem_write, jal_mem} <=
            {reg_write_ex, mem_to_reg_ex, mem_write_ex, jal_ex};
         {reg_write_wb, mem_to_reg_wb} <= {reg_write_mem, mem_to_reg_mem};
      end
   end

   always_ff @(posedge clk)
   begin
      rd_mem     <= rd_ex;
      alu_mem    <= result_ex;
      link_mem   <= link_ex;
      store_data <= store_data_ex;
      rd_wb      <= rd_mem;
      result_wb  <= result_mem;
      load_wb    <= mem_rdata;                     // captured for loads
   end

   // jal link is chosen here so forwarding sees it too
   assign result_mem = jal_mem ? link_mem : alu_mem;
   assign rd_data_wb = mem_to_reg_wb ? load_wb : result_wb;

endmodule

`default_nettype wire

// ==== verilog/rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_core (
   input  logic          clk,
   input  logic          reset,
   output rv_pkg::word_t pc,
   input  rv_pkg::word_t inst,
   output logic          mem_write,
   output rv_pkg::word_t mem_addr,
   output rv_pkg::word_t mem_wdata,
   input  rv_pkg::word_t mem_rdata
);
   import rv_pkg::*;

   word_t     inst_id;
   word_t     pc_id;
   reg_addr_t rs1_id;
   reg_addr_t rs2_id;
   reg_addr_t rd_id;
   logic      reg_write_id;
   logic      mem_to_reg_id;
   logic      mem_write_id;
   logic      alu_src_imm_id;
   logic      branch_id;
   logic      jal_id;
   logic      lui_id;
   logic      uses_rs2_id;
   alu_op_t   alu_op_id;
   word_t     imm_id;
   word_t     rs1_data;
   word_t     rs2_data;
   fwd_sel_t  fwd_a;
   fwd_sel_t  fwd_b;
   logic      stall;
   reg_addr_t rs1_ex;
   reg_addr_t rs2_ex;
   reg_addr_t rd_ex;
   logic      mem_to_reg_ex;
   logic      reg_write_ex;
   logic      mem_write_ex;
   logic      jal_ex;
   word_t     result_ex;
   word_t     store_data_ex;
   word_t     link_ex;
   word_t     target;
   logic      redirect;
   logic      reg_write_mem;
   logic      reg_write_wb;
   word_t     result_mem;
   word_t     store_data;
   word_t     rd_data_wb;
   reg_addr_t rd_mem;
   reg_addr_t rd_wb;

   // --------------------------------------------------
   // fetch and IF/ID
   // --------------------------------------------------
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         pc      <= reset_pc;
         inst_id <= nop_inst;
      end
      else if (redirect)
      begin
         pc      <= target;
         inst_id <= nop_inst;                      // squash the younger slot
      end
      else if (!stall)
      begin
         pc      <= pc + pc_step;
         inst_id <= inst;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!stall)
         pc_id <= pc;
   end

   assign rs1_id = inst_id[19:15];
   assign rs2_id = inst_id[24:20];
   assign rd_id  = inst_id[11:7];

   // --------------------------------------------------
   // stages
   // --------------------------------------------------
   rv_decoder decoder0 (
      .inst        (inst_id),
      .reg_write   (reg_write_id),
      .mem_to_reg  (mem_to_reg_id),
      .mem_write   (mem_write_id),
      .alu_src_imm (alu_src_imm_id),
      .branch      (branch_id),
      .jal         (jal_id),
      .lui         (lui_id),
      .uses_rs2    (uses_rs2_id),
      .alu_op      (alu_op_id),
      .imm         (imm_id)
   );

   rv_regfile regfile0 (
      .clk      (clk),
      .we       (reg_write_wb),
      .rs1      (rs1_id),
      .rs2      (rs2_id),
      .rd       (rd_wb),
      .rd_data  (rd_data_wb),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data)
   );

   rv_hazard_unit hazard0 (
      .rs1_id        (rs1_id),
      .rs2_id        (rs2_id),
      .rs1_ex        (rs1_ex),
      .rs2_ex        (rs2_ex),
      .rd_ex         (rd_ex),
      .rd_mem        (rd_mem),
      .rd_wb         (rd_wb),
      .uses_rs2_id   (uses_rs2_id),
      .mem_to_reg_ex (mem_to_reg_ex),
      .reg_write_mem (reg_write_mem),
      .reg_write_wb  (reg_write_wb),
      .fwd_a         (fwd_a),
      .fwd_b         (fwd_b),
      .stall         (stall)
   );

   rv_execute execute0 (
      .clk            (clk),
      .reset          (reset),
      .stall          (stall),
      .pc_id          (pc_id),
      .reg_write_id   (reg_write_id),
      .mem_to_reg_id  (mem_to_reg_id),
      .mem_write_id   (mem_write_id),
      .alu_src_imm_id (alu_src_imm_id),
      .branch_id      (branch_id),
      .jal_id         (jal_id),
      .lui_id         (lui_id),
      .alu_op_id      (alu_op_id),
      .imm_id         (imm_id),
      .rs1_id         (rs1_id),
      .rs2_id         (rs2_id),
      .rd_id          (rd_id),
      .rs1_data       (rs1_data),
      .rs2_data       (rs2_data),
      .funct3_id      (branch_cond_t'(inst_id[14:12])),
      .fwd_a          (fwd_a),
      .fwd_b          (fwd_b),
      .result_mem     (result_mem),
      .rd_data_wb     (rd_data_wb),
      .rs1_ex         (rs1_ex),
      .rs2_ex         (rs2_ex),
      .rd_ex          (rd_ex),
      .mem_to_reg_ex  (mem_to_reg_ex),
      .reg_write_ex   (reg_write_ex),
      .mem_write_ex   (mem_write_ex),
      .jal_ex         (jal_ex),
      .result_ex      (result_ex),
      .store_data_ex  (store_data_ex),
      .link_ex        (link_ex),
      .target         (target),
      .redirect       (redirect)
   );

   rv_mem_wb mem_wb0 (
      .clk           (clk),
      .reset         (reset),
      .rd_ex         (rd_ex),
      .reg_write_ex  (reg_write_ex),
      .mem_to_reg_ex (mem_to_reg_ex),
      .mem_write_ex  (mem_write_ex),
      .jal_ex        (jal_ex),
      .result_ex     (result_ex),
      .store_data_ex (store_data_ex),
      .link_ex       (link_ex),
      .mem_rdata     (mem_rdata),
      .mem_write     (mem_write),
      .reg_write_mem (reg_write_mem),
      .reg_write_wb  (reg_write_wb),
      .result_mem    (result_mem),
      .store_data    (store_data),
      .rd_data_wb    (rd_data_wb),
      .rd_mem        (rd_mem),
      .rd_wb         (rd_wb)
   );

   assign mem_addr  = result_mem;                  // address from EX/MEM
   assign mem_wdata = store_data;

endmodule

`default_nettype wire

// ==== dv/rv_core_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_core_assertions (
   input logic          clk,
   input logic          reset,
   input rv_pkg::word_t pc,
   input logic          mem_write,
   input logic          stall,
   input logic          redirect
);
   import rv_pkg::*;

   // --------------------------------------------------
   // store strobe
   // --------------------------------------------------
   no_store_in_reset: assert property (@(posedge clk) reset |-> !mem_write)
      else $error("mem_write high during reset");

   store_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(mem_write))
      else $error("mem_write unknown after reset");

   // --------------------------------------------------
   // fetch address
   // --------------------------------------------------
   pc_aligned: assert property (@(posedge clk) (pc % pc_step) == 0)
      else $error("pc %h is not word aligned", pc);

   // a redirect in the same cycle still moves the pc
   pc_held_in_stall: assert property (@(posedge clk) disable iff (reset)
                                      stall && !redirect |=> pc == $past(pc))
      else $error("pc moved during a load-use stall");

endmodule

bind rv_core rv_core_assertions assertions0 (
   .clk       (clk),
   .reset     (reset),
   .pc        (pc),
   .mem_write (mem_write),
   .stall     (stall),
   .redirect  (redirect)
);

`default_nettype wire

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;
   import rv_pkg::*;

   localparam int    seed            = 22359;
   localparam int    reset_cycles    = 10;
   localparam int    cycles_per_word = 20;
   localparam int    timeout_base    = 100;
   localparam int    imem_words      = 256;
   localparam int    dmem_words      = 256;
   localparam int    loop_period     = 3;        // jal-to-self refetches every third cycle
   localparam int    loop_checks     = 3;
   localparam string data_file       = "dv/rv_core_testdata.mem";

   logic  clk;
   logic  reset;
   word_t pc;
   word_t inst;
   logic  mem_write;
   word_t mem_addr;
   word_t mem_wdata;
   word_t mem_rdata;

   word_t imem [imem_words];
   word_t dmem [dmem_words];
   word_t exp_addr [$];                          // expected stores, oldest first
   word_t exp_data [$];
   word_t loop_pc;
   int    program_words = 0;
   int    timeout_limit = 0;
   int    cycle_count   = 0;

   rv_core dut0 (
      .clk       (clk),
      .reset     (reset),
      .pc        (pc),
      .inst      (inst),
      .mem_write (mem_write),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

   // --------------------------------------------------
   // memory models
   // --------------------------------------------------
   assign inst      = imem[pc[9:2]];
   assign mem_rdata = dmem[mem_addr[9:2]];

   always @(posedge clk)
   begin
      if (mem_write === 1'b1)
         dmem[mem_addr[9:2]] <= mem_wdata;
   end

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic report_mismatch(input string msg);
      abort_run($sformatf("FAILED at %0t ns: %s", $time, msg));
   endtask

   task automatic check_store(input word_t addr, input word_t data);
      word_t want_addr;
      word_t want_data;
      want_addr = exp_addr.pop_front();
      want_data = exp_data.pop_front();
      if (addr !== want_addr || data !== want_data)
         report_mismatch($sformatf("store of %h to %h, expected %h to %h",
                                   data, addr, want_data, want_addr));
   endtask

   task automatic check_pc(input word_t got, input word_t want);
      if (got !== want)
         report_mismatch($sformatf("pc is %h, expected %h", got, want));
   endtask

   task automatic fill_memories();
      for (int i = 0; i < imem_words; i++)
         imem[i] = {i[24:0], 7'b0000000};        // opcode 0 has no effect
      for (int i = 0; i < dmem_words; i++)
         dmem[i] = $urandom();
   endtask

   // one record per line, lines that do not parse are comments
   task automatic load_testdata();
      int    fd;
      int    kind;
      word_t addr;
      word_t value;
      string line;
      fd = $fopen(data_file, "r");
      if (fd == 0)
         abort_run("could not open the test data file");
      else
      begin
         while ($fgets(line, fd) != 0)
         begin
            if ($sscanf(line, "%h %h %h", kind, addr, value) == 3)
            begin
               if (kind == 0)
               begin
                  imem[addr[9:2]] = value;
                  loop_pc         = addr;        // last word is the final loop
                  program_words++;
               end
               else
               begin
                  exp_addr.push_back(addr);
                  exp_data.push_back(value);
               end
            end
         end
         $fclose(fd);
         timeout_limit = program_words * cycles_per_word + timeout_base;
      end
   endtask

   // --------------------------------------------------
   // store monitor and timeout
   // --------------------------------------------------
   always @(negedge clk)
   begin
      if (mem_write === 1'b1)
      begin
         if (exp_addr.size() == 0)
            abort_run("a store appeared when no further store was expected");
         else
            check_store(mem_addr, mem_wdata);
      end
   end

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count > timeout_limit)
         abort_run($sformatf("timeout after %0d cycles without reaching the final loop",
                             timeout_limit));
   end

   initial
   begin
      reset     = 1'b1;
      void'($urandom(seed));
      fill_memories();
      load_testdata();
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      check_pc(pc, reset_pc);
      reset = 1'b0;
      while (pc !== loop_pc)
         @(negedge clk);
      for (int i = 0; i < loop_checks; i++)
      begin
         repeat (loop_period) @(negedge clk);
         check_pc(pc, loop_pc);
      end
      if (exp_addr.size() != 0)
         abort_run("expected stores were still waiting at the end of the run");
      else
      begin
         $display("No errors");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== dv/rv_core_testdata.mem ====
// kind address value, all hex
// kind 0 is a program word, kind 1 is an expected store in order
// forwarding chain through R-type and immediate ops
0 00000000 00500093
0 00000004 00708113
0 00000008 002081B3
0 0000000C 40118233
0 00000010 0FF24293
0 00000014 00429313
0 00000018 005373B3
0 0000001C 0043E433
0 00000020 00F47493
0 00000024 1004E513
0 00000028 00A02623
0 0000002C 00302023
0 00000030 00602223
0 00000034 00802423
0 00000038 00502823
// lui and addi constants
0 0000003C 123455B7
0 00000040 67858593
0 00000044 00B02A23
0 00000048 DEADC637
0 0000004C EEF60613
0 00000050 00C02C23
// load-use on rs1 and on store data
0 00000054 01402683
0 00000058 00168733
0 0000005C 00E02E23
0 00000060 01802783
0 00000064 02F02023
// branches, each followed by two store slots
0 00000068 FFF00813
0 0000006C 00108663
0 00000070 04102023
0 00000074 04402223
0 00000078 00408663
0 0000007C 04102423
0 00000080 04402623
0 00000084 00409663
0 00000088 04102823
0 0000008C 04402A23
0 00000090 00109663
0 00000094 04102C23
0 00000098 04402E23
0 0000009C 00184663
0 000000A0 06102023
0 000000A4 06402223
0 000000A8 0100C663
0 000000AC 06102423
0 000000B0 06402623
0 000000B4 0100D663
0 000000B8 06102823
0 000000BC 06402A23
0 000000C0 00185663
0 000000C4 06102C23
0 000000C8 06402E23
0 000000CC 0100E663
0 000000D0 08102023
0 000000D4 08402223
0 000000D8 00186663
0 000000DC 08102423
0 000000E0 08402623
0 000000E4 00187663
0 000000E8 08102823
0 000000EC 08402A23
0 000000F0 0100F663
0 000000F4 08102C23
0 000000F8 08402E23
// jal over two stores, then link stored, then jal to self
0 000000FC 00C008EF
0 00000100 0A102023
0 00000104 0A102223
0 00000108 0B102423
0 0000010C 0000006F
// expected stores
1 0000000C 0000010C
1 00000000 00000011
1 00000004 00000F30
1 00000008 0000003C
1 00000010 000000F3
1 00000014 12345678
1 00000018 DEADBEEF
1 0000001C 1234567D
1 00000020 DEADBEEF
1 00000048 00000005
1 0000004C 0000000C
1 00000058 00000005
1 0000005C 0000000C
1 00000068 00000005
1 0000006C 0000000C
1 00000078 00000005
1 0000007C 0000000C
1 00000088 00000005
1 0000008C 0000000C
1 00000098 00000005
1 0000009C 0000000C
1 000000A8 00000100

// ==== list.f ====
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_hazard_unit.sv
verilog/rv_execute.sv
verilog/rv_mem_wb.sv
verilog/rv_core.sv
dv/rv_core_assertions.sv
dv/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - verilog/rv_pkg.sv
  - verilog/rv_decoder.sv
  - verilog/rv_regfile.sv
  - verilog/rv_alu.sv
  - verilog/rv_hazard_unit.sv
  - verilog/rv_execute.sv
  - verilog/rv_mem_wb.sv
  - verilog/rv_core.sv
  - target: simulation
    files:
      - dv/rv_core_assertions.sv
      - dv/rv_core_tb.sv
